/* include/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Byte address width
`define CACHE_ADDR_W 32

// Processor data word width
`define CACHE_WORD_W 32

// Bytes held by one cache line
`define CACHE_LINE_BYTES 32

`define CACHE_SETS 8

// Associativity, the datapath is built for two ways
`define CACHE_WAYS 2

`endif

/* src/cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

	localparam int OFFSET_W = $clog2(`CACHE_LINE_BYTES);
	localparam int SET_W = $clog2(`CACHE_SETS);
	localparam int TAG_W = `CACHE_ADDR_W - SET_W - OFFSET_W;

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_WORD_W-1:0] word_t;
	typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;
	typedef logic [`CACHE_WORD_W/8-1:0] byte_en_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [SET_W-1:0] set_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	typedef enum logic [1:0] {
		IDLE,
		COMPARE,
		WRITEBACK,
		FILL
	} ctrl_state_t;

endpackage

/* src/l1d_datapath.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module l1d_datapath (
	input  logic                clk,
	input  logic                arst_n,
	input  cache_pkg::addr_t    req_addr,
	input  cache_pkg::word_t    req_wdata,
	input  cache_pkg::byte_en_t req_byte_en,
	input  cache_pkg::line_t    pmem_rdata,
	input  logic                load_req,
	input  logic                load_fill,
	input  logic                write_hit,
	input  logic                set_lru,
	input  logic                victim_sel_addr,
	output logic                hit,
	output logic                hit_way,
	output logic                victim_dirty,
	output cache_pkg::word_t    resp_rdata,
	output cache_pkg::addr_t    pmem_addr,
	output cache_pkg::line_t    pmem_wdata
);

	localparam int WORD_BYTES = `CACHE_WORD_W / 8;
	localparam int WSEL_W = cache_pkg::OFFSET_W - $clog2(WORD_BYTES);

	// Captured request
	cache_pkg::addr_t    addr_q;
	cache_pkg::word_t    wdata_q;
	cache_pkg::byte_en_t byte_en_q;

	cache_pkg::tag_t    tag;
	cache_pkg::set_t    set_idx;
	cache_pkg::offset_t offset;
	logic [WSEL_W-1:0]  word_sel;

	// Storage, tag and data arrays carry no reset
	cache_pkg::tag_t  tag_arr  [`CACHE_WAYS][`CACHE_SETS];
	cache_pkg::line_t data_arr [`CACHE_WAYS][`CACHE_SETS];
	logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid_q;
	logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty_q;
	logic [`CACHE_SETS-1:0] lru_q; // Holds the least recently used way

	logic [`CACHE_WAYS-1:0] way_hit;
	logic                   victim_way;
	cache_pkg::tag_t        victim_tag;
	cache_pkg::line_t       hit_line;
	cache_pkg::line_t       merged_line;

	always_ff @(posedge clk) begin
		if (load_req) begin
			addr_q <= req_addr;
			wdata_q <= req_wdata;
			byte_en_q <= req_byte_en;
		end
	end

	assign {tag, set_idx, offset} = addr_q;
	assign word_sel = offset[cache_pkg::OFFSET_W-1 -: WSEL_W];

	// Tag compare in both ways
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			way_hit[w] = valid_q[w][set_idx] && (tag_arr[w][set_idx] == tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1]; // Way 0 unless way 1 matches

	assign victim_way = lru_q[set_idx];
	assign victim_tag = tag_arr[victim_way][set_idx];
	assign victim_dirty = valid_q[victim_way][set_idx] && dirty_q[victim_way][set_idx];

	// Line aligned memory address, writeback uses the stored tag
	always_comb begin
		if (victim_sel_addr) begin
			pmem_addr = {victim_tag, set_idx, cache_pkg::offset_t'(0)};
		end else begin
			pmem_addr = {tag, set_idx, cache_pkg::offset_t'(0)};
		end
	end

	assign pmem_wdata = data_arr[victim_way][set_idx];

	assign hit_line = data_arr[hit_way][set_idx];
	assign resp_rdata = hit_line[word_sel*`CACHE_WORD_W +: `CACHE_WORD_W];

	// Only the enabled lanes of the addressed word change
	always_comb begin
		merged_line = hit_line;
		for (int b = 0; b < WORD_BYTES; b++) begin
			if (byte_en_q[b]) begin
				merged_line[word_sel*`CACHE_WORD_W + b*8 +: 8] = wdata_q[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_fill) begin
			data_arr[victim_way][set_idx] <= pmem_rdata;
			tag_arr[victim_way][set_idx] <= tag;
		end else if (write_hit) begin
			data_arr[hit_way][set_idx] <= merged_line;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end else begin
			if (load_fill) begin
				valid_q[victim_way][set_idx] <= 1'b1;
				dirty_q[victim_way][set_idx] <= 1'b0; // Fresh line matches memory
			end else if (write_hit) begin
				dirty_q[hit_way][set_idx] <= 1'b1;
			end
			if (set_lru) begin
				lru_q[set_idx] <= ~hit_way; // Other way becomes the victim
			end
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) write_hit |-> hit)
		else $error("write_hit asserted without a tag hit");

	// The refilled line must satisfy the pending request on the next lookup
	assert property (@(posedge clk) disable iff (!arst_n) load_fill |=> hit)
		else $error("lookup after fill did not hit");

endmodule

/* src/l1d_control.sv */
`timescale 1ns/1ps

module l1d_control (
	input  logic clk,
	input  logic arst_n,
	input  logic req_valid,
	input  logic req_write,
	output logic req_ready,
	output logic resp_valid,
	input  logic hit,
	input  logic victim_dirty,
	output logic load_req,
	output logic load_fill,
	output logic write_hit,
	output logic set_lru,
	output logic victim_sel_addr,
	output logic pmem_valid,
	output logic pmem_write,
	input  logic pmem_ready
);

	cache_pkg::ctrl_state_t state_q;
	cache_pkg::ctrl_state_t state_d;
	logic write_q; // Accepted request is a store

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= cache_pkg::IDLE;
			write_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (load_req) begin
				write_q <= req_write;
			end
		end
	end

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			cache_pkg::IDLE: begin
				if (req_valid) begin
					state_d = cache_pkg::COMPARE;
				end
			end
			cache_pkg::COMPARE: begin
				if (hit) begin
					state_d = cache_pkg::IDLE;
				end else if (victim_dirty) begin
					state_d = cache_pkg::WRITEBACK;
				end else begin
					state_d = cache_pkg::FILL;
				end
			end
			cache_pkg::WRITEBACK: begin
				if (pmem_ready) begin
					state_d = cache_pkg::FILL;
				end
			end
			cache_pkg::FILL: begin
				if (pmem_ready) begin
					state_d = cache_pkg::COMPARE; // Retry the lookup
				end
			end
			default: begin
				state_d = cache_pkg::IDLE;
			end
		endcase
	end

	assign req_ready = (state_q == cache_pkg::IDLE);
	assign load_req = req_ready && req_valid;

	assign resp_valid = (state_q == cache_pkg::COMPARE) && hit;
	assign set_lru = resp_valid;
	assign write_hit = resp_valid && write_q;

	assign pmem_valid = (state_q == cache_pkg::WRITEBACK) || (state_q == cache_pkg::FILL);
	assign pmem_write = (state_q == cache_pkg::WRITEBACK);
	assign victim_sel_addr = (state_q == cache_pkg::WRITEBACK);
	assign load_fill = (state_q == cache_pkg::FILL) && pmem_ready;

	assert property (@(posedge clk) disable iff (!arst_n)
		pmem_valid |-> (state_q inside {cache_pkg::WRITEBACK, cache_pkg::FILL}))
		else $error("memory request outside WRITEBACK or FILL");

	assert property (@(posedge clk) disable iff (!arst_n) resp_valid |-> hit)
		else $error("response without a hit");

endmodule

/* src/l1d_cache.sv */
`timescale 1ns/1ps

module l1d_cache (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                req_valid,
	input  logic                req_write,
	input  cache_pkg::addr_t    req_addr,
	input  cache_pkg::word_t    req_wdata,
	input  cache_pkg::byte_en_t req_byte_en,
	output logic                req_ready,
	output logic                resp_valid,
	output cache_pkg::word_t    resp_rdata,
	output logic                pmem_valid,
	output logic                pmem_write,
	output cache_pkg::addr_t    pmem_addr,
	output cache_pkg::line_t    pmem_wdata,
	input  cache_pkg::line_t    pmem_rdata,
	input  logic                pmem_ready
);

	logic hit;
	logic victim_dirty;
	logic load_req;
	logic load_fill;
	logic write_hit;
	logic set_lru;
	logic victim_sel_addr;

	l1d_datapath datapath_i (
		.clk(clk),
		.arst_n(arst_n),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_byte_en(req_byte_en),
		.pmem_rdata(pmem_rdata),
		.load_req(load_req),
		.load_fill(load_fill),
		.write_hit(write_hit),
		.set_lru(set_lru),
		.victim_sel_addr(victim_sel_addr),
		.hit(hit),
		.hit_way(), // Consumed inside the datapath only
		.victim_dirty(victim_dirty),
		.resp_rdata(resp_rdata),
		.pmem_addr(pmem_addr),
		.pmem_wdata(pmem_wdata)
	);

	l1d_control control_i (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.load_req(load_req),
		.load_fill(load_fill),
		.write_hit(write_hit),
		.set_lru(set_lru),
		.victim_sel_addr(victim_sel_addr),
		.pmem_valid(pmem_valid),
		.pmem_write(pmem_write),
		.pmem_ready(pmem_ready)
	);

endmodule

/* dv/pmem_model.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module pmem_model (
	input  logic             clk,
	input  logic             pmem_valid,
	input  logic             pmem_write,
	input  cache_pkg::addr_t pmem_addr,
	input  cache_pkg::line_t pmem_wdata,
	output cache_pkg::line_t pmem_rdata,
	output logic             pmem_ready,
	output int               req_count
);

	localparam int MAX_DELAY = 5;
	localparam int SEED = 49;

	cache_pkg::line_t mem [cache_pkg::addr_t]; // Lines that were written back

	// Each byte holds the XOR of the four bytes of its own address
	function automatic cache_pkg::line_t image_line(input cache_pkg::addr_t line_addr);
		cache_pkg::line_t line;
		cache_pkg::addr_t a;
		for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
			a = line_addr + cache_pkg::addr_t'(i);
			line[i*8 +: 8] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
		end
		return line;
	endfunction

	initial begin
		int delay;
		void'($urandom(SEED)); // Ready delays come from this process
		pmem_ready = 1'b0;
		pmem_rdata = '0;
		req_count = 0;
		forever begin
			@(negedge clk);
			pmem_ready = 1'b0; // Ready lasts one cycle
			if (pmem_valid) begin
				delay = $urandom % (MAX_DELAY + 1);
				repeat (delay) begin
					@(negedge clk);
				end
				if (pmem_write) begin
					mem[pmem_addr] = pmem_wdata;
				end else if (mem.exists(pmem_addr)) begin
					pmem_rdata = mem[pmem_addr];
				end else begin
					pmem_rdata = image_line(pmem_addr); // Never written, initial image
				end
				pmem_ready = 1'b1;
				req_count++;
			end
		end
	end

endmodule

/* dv/tb_l1d_cache.sv */
`timescale 1ns/1ps

module tb_l1d_cache;

	localparam int CYCLES_PER_TEST = 200;
	localparam cache_pkg::addr_t NO_ADDR = '1; // Address column left unchecked

	logic                clk;
	logic                arst_n;
	logic                req_valid;
	logic                req_write;
	cache_pkg::addr_t    req_addr;
	cache_pkg::word_t    req_wdata;
	cache_pkg::byte_en_t req_byte_en;
	logic                req_ready;
	logic                resp_valid;
	cache_pkg::word_t    resp_rdata;
	logic                pmem_valid;
	logic                pmem_write;
	cache_pkg::addr_t    pmem_addr;
	cache_pkg::line_t    pmem_wdata;
	cache_pkg::line_t    pmem_rdata;
	logic                pmem_ready;
	int                  req_count;

	// One entry per access from the data file
	logic                t_write [$];
	cache_pkg::addr_t    t_addr [$];
	cache_pkg::word_t    t_wdata [$];
	cache_pkg::byte_en_t t_byte_en [$];
	cache_pkg::word_t    t_rdata [$];
	int                  t_mem_reqs [$];
	cache_pkg::addr_t    t_wb_addr [$];
	cache_pkg::addr_t    t_fill_addr [$];

	logic             xfer_write [$]; // Memory transfers in bus order
	cache_pkg::addr_t xfer_addr [$];

	int n_tests = 0;
	int cur_test = 0;
	bit tests_loaded = 1'b0;
	int resp_count = 0;
	int checks = 0;
	int errors = 0;

	l1d_cache dut_i (.*);

	pmem_model mem_i (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Sampled at the rising edge, ahead of the register updates
	always @(posedge clk) begin
		if (arst_n && pmem_valid && pmem_ready) begin
			xfer_write.push_back(pmem_write);
			xfer_addr.push_back(pmem_addr);
		end
		if (arst_n && resp_valid) begin
			resp_count++;
		end
	end

	task automatic check_word(input string name, input cache_pkg::word_t got,
		input cache_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail: test %0d %s got %h expected %h", cur_test + 1, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input cache_pkg::addr_t got,
		input cache_pkg::addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail: test %0d %s got %h expected %h", cur_test + 1, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail: test %0d %s got %h expected %h", cur_test + 1, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Fail: test %0d %s got %h expected %h", cur_test + 1, name, got, exp);
		end
	endtask

	task automatic load_tests();
		int fd;
		int n;
		string line;
		logic [7:0] op;
		cache_pkg::addr_t addr;
		cache_pkg::word_t wdata;
		cache_pkg::byte_en_t byte_en;
		cache_pkg::word_t rdata;
		int mem_reqs;
		cache_pkg::addr_t wb_addr;
		cache_pkg::addr_t fill_addr;
		fd = $fopen("dv/cache_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the test data file dv/cache_tests.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%c %h %h %h %h %d %h %h", op, addr, wdata, byte_en, rdata,
				mem_reqs, wb_addr, fill_addr);
			if (n != 8) begin
				errors++;
				$display("Malformed line in the test data file: %s", line);
				continue;
			end
			t_write.push_back(op == "W");
			t_addr.push_back(addr);
			t_wdata.push_back(wdata);
			t_byte_en.push_back(byte_en);
			t_rdata.push_back(rdata);
			t_mem_reqs.push_back(mem_reqs);
			t_wb_addr.push_back(wb_addr);
			t_fill_addr.push_back(fill_addr);
		end
		$fclose(fd);
		n_tests = t_addr.size();
	endtask

	task automatic run_access(input int idx);
		int mem_before;
		int first;
		int fill_pos;
		mem_before = req_count;
		first = xfer_addr.size();
		req_valid = 1'b1;
		req_write = t_write[idx];
		req_addr = t_addr[idx];
		req_wdata = t_wdata[idx];
		req_byte_en = t_byte_en[idx];
		while (!req_ready) begin
			@(negedge clk);
		end
		@(negedge clk); // Accepted at the rising edge just passed
		req_valid = 1'b0;
		while (!resp_valid) begin
			@(negedge clk);
		end
		if (!t_write[idx]) begin
			check_word("resp_rdata", resp_rdata, t_rdata[idx]);
		end
		check_count("pmem request count", req_count - mem_before, t_mem_reqs[idx]);
		if (t_mem_reqs[idx] > 0 && xfer_addr.size() >= first + t_mem_reqs[idx]) begin
			fill_pos = first + t_mem_reqs[idx] - 1;
			if (t_mem_reqs[idx] == 2) begin
				check_flag("pmem_write", xfer_write[first], 1'b1);
				if (t_wb_addr[idx] != NO_ADDR) begin
					check_addr("pmem_addr", xfer_addr[first], t_wb_addr[idx]);
				end
			end
			check_flag("pmem_write", xfer_write[fill_pos], 1'b0);
			if (t_fill_addr[idx] != NO_ADDR) begin
				check_addr("pmem_addr", xfer_addr[fill_pos], t_fill_addr[idx]);
			end
		end
	endtask

	task automatic print_summary();
		$display("Tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
	endtask

	initial begin
		arst_n = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_byte_en = '0;
		load_tests();
		tests_loaded = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_flag("req_ready", req_ready, 1'b1); // Controller idles after reset
		check_flag("resp_valid", resp_valid, 1'b0);
		check_flag("pmem_valid", pmem_valid, 1'b0);
		for (int i = 0; i < n_tests; i++) begin
			cur_test = i;
			run_access(i);
		end
		@(posedge clk);
		@(negedge clk);
		check_count("resp_valid pulses", resp_count, n_tests); // One per request
		print_summary();
		if (errors == 0 && checks > 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		wait (tests_loaded);
		repeat (n_tests * CYCLES_PER_TEST + 20) @(posedge clk);
		$display("Timeout: test %0d of %0d never got its response", cur_test + 1, n_tests);
		print_summary();
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
src/cache_pkg.sv
src/l1d_datapath.sv
src/l1d_control.sv
src/l1d_cache.sv
dv/pmem_model.sv
dv/tb_l1d_cache.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_l1d_cache \
	-Mdir obj_dir -o tb_l1d_cache

./obj_dir/tb_l1d_cache | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* dv/cache_tests.txt */
# op addr wdata byte_en exp_rdata mem_reqs wb_addr fill_addr (all hex except mem_reqs)
# ffffffff in an address column means no address is checked, exp_rdata is ignored on writes
# Cold reads fill from the initial image
R 00000000 00000000 0 03020100 1 ffffffff 00000000
R 00000024 00000000 0 27262524 1 ffffffff 00000020
R 12345678 00000000 0 0b0a0908 1 ffffffff 12345660
R 0000005c 00000000 0 5f5e5d5c 1 ffffffff 00000040
R fedcba98 00000000 0 03020100 1 ffffffff fedcba80
# Hits cause no memory requests
R 00000000 00000000 0 03020100 0 ffffffff ffffffff
R 0000001c 00000000 0 1f1e1d1c 0 ffffffff ffffffff
R 00000020 00000000 0 23222120 0 ffffffff ffffffff
R 12345660 00000000 0 13121110 0 ffffffff ffffffff
R fedcba9c 00000000 0 07060504 0 ffffffff ffffffff
# Partial byte enables
W 00000004 aabbccdd 1 00000000 0 ffffffff ffffffff
R 00000004 00000000 0 070605dd 0 ffffffff ffffffff
W 00000008 11223344 6 00000000 0 ffffffff ffffffff
R 00000008 00000000 0 0b223308 0 ffffffff ffffffff
W 00000024 cafef00d c 00000000 0 ffffffff ffffffff
R 00000024 00000000 0 cafe2524 0 ffffffff ffffffff
W 00000028 5a5a5a5a f 00000000 0 ffffffff ffffffff
R 00000028 00000000 0 5a5a5a5a 0 ffffffff ffffffff
W 0000000c ffffffff 0 00000000 0 ffffffff ffffffff
R 0000000c 00000000 0 0f0e0d0c 0 ffffffff ffffffff
# Write miss allocates
W 000000a0 12345678 3 00000000 1 ffffffff 000000a0
R 000000a0 00000000 0 a3a25678 0 ffffffff ffffffff
# Three lines in set 0, dirty victims are written back
R 00000100 00000000 0 02030001 1 ffffffff 00000100
W 00000104 deadbeef f 00000000 0 ffffffff ffffffff
R 00000000 00000000 0 03020100 0 ffffffff ffffffff
R 00000200 00000000 0 01000302 2 00000100 00000200
R 00000104 00000000 0 deadbeef 2 00000000 00000100
R 00000004 00000000 0 070605dd 1 ffffffff 00000000
R 00000008 00000000 0 0b223308 0 ffffffff ffffffff
R 00000100 00000000 0 02030001 0 ffffffff ffffffff
# Set 1 eviction of a partially written line
R 00000320 00000000 0 20212223 1 ffffffff 00000320
R 00000420 00000000 0 27262524 2 00000020 00000420
R 00000024 00000000 0 cafe2524 1 ffffffff 00000020
R 00000028 00000000 0 5a5a5a5a 0 ffffffff ffffffff
# Set 5 write misses with dirty victims
W 000001bc 01020304 f 00000000 1 ffffffff 000001a0
W 000002b0 0000ffff 3 00000000 2 000000a0 000002a0
R 000002b0 00000000 0 b1b0ffff 0 ffffffff ffffffff
R 000000a0 00000000 0 a3a25678 2 000001a0 000000a0
R 000001bc 00000000 0 01020304 2 000002a0 000001a0
R 000002b0 00000000 0 b1b0ffff 1 ffffffff 000002a0
# Set 7 lines that differ only in the upper address bits
R 8000e0f0 00000000 0 93929190 1 ffffffff 8000e0e0
R 4000e0f0 00000000 0 53525150 1 ffffffff 4000e0e0
R 8000e0f4 00000000 0 97969594 0 ffffffff ffffffff
R 4000e0fc 00000000 0 5f5e5d5c 0 ffffffff ffffffff
